//--- mul_isa_pkg.sv
package mul_isa_pkg;

	localparam int xlen_default = 64;

	// values follow the funct3 field of the M extension.
	typedef enum logic [2:0] {
		op_mul    = 3'b000,
		op_mulh   = 3'b001,
		op_mulhsu = 3'b010,
		op_mulhu  = 3'b011
	} mul_op_e;

	typedef struct packed {
		mul_op_e                 op;
		logic                    word;   // set for mulw.
		logic [xlen_default-1:0] src1;
		logic [xlen_default-1:0] src2;
	} mul_req_t;

	typedef struct packed {
		logic [xlen_default-1:0] result;
	} mul_rsp_t;

endpackage

//--- mul_dp_pkg.sv
package mul_dp_pkg;

	localparam int dp_xlen = mul_isa_pkg::xlen_default;

	typedef struct packed {
		logic src1_signed;
		logic src2_signed;
	} sign_mode_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2   // applies the top booth window.
	} booth_state_e;

	typedef struct packed {
		logic [dp_xlen-1:0] hi;
		logic [dp_xlen-1:0] lo;
	} product_half_t;

	typedef union packed {
		logic [2*dp_xlen-1:0] full;
		product_half_t        half;
	} product_u;

	// operands carry two extra bits so one booth core covers every sign mode.
	typedef struct packed {
		logic [dp_xlen+1:0]   mcand;
		logic [dp_xlen+1:0]   mplier;
		mul_isa_pkg::mul_op_e op;
		logic                 word;
	} prep_opnd_t;

endpackage

//--- mul_operand_prep.sv
module mul_operand_prep #(
	parameter int XLEN = mul_isa_pkg::xlen_default
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	input  mul_isa_pkg::mul_req_t  req,
	output logic                   req_ready,
	input  logic                   busy,
	output logic                   opnd_valid,
	output mul_dp_pkg::prep_opnd_t opnd
);
	import mul_isa_pkg::*;
	import mul_dp_pkg::*;

	localparam int WW = 32;

	sign_mode_t      smode;
	logic [XLEN-1:0] src_a;
	logic [XLEN-1:0] src_b;
	logic            pending;
	logic            accept;

	assign accept    = req_valid && req_ready;
	assign req_ready = !pending && !busy;

	always_comb begin
		case (req.op)
			op_mul, op_mulh: smode = '{src1_signed: 1'b1, src2_signed: 1'b1};
			op_mulhsu:       smode = '{src1_signed: 1'b1, src2_signed: 1'b0};
			op_mulhu:        smode = '{src1_signed: 1'b0, src2_signed: 1'b0};
			default:         smode = '{src1_signed: 1'b1, src2_signed: 1'b1};
		endcase
	end

	// word ops work on the sign-extended low halves.
	always_comb begin
		if (req.word) begin
			src_a = {{(XLEN-WW){req.src1[WW-1]}}, req.src1[WW-1:0]};
			src_b = {{(XLEN-WW){req.src2[WW-1]}}, req.src2[WW-1:0]};
		end else begin
			src_a = req.src1;
			src_b = req.src2;
		end
	end

	// pending drops once the core is idle and its response has left.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending    <= 1'b0;
			opnd_valid <= 1'b0;
		end else begin
			opnd_valid <= accept;
			if (accept)
				pending <= 1'b1;
			else if (!busy && !opnd_valid)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			opnd.mcand  <= {{2{smode.src1_signed & src_a[XLEN-1]}}, src_a};
			opnd.mplier <= {{2{smode.src2_signed & src_b[XLEN-1]}}, src_b};
			opnd.op     <= req.op;
			opnd.word   <= req.word;
		end
	end

endmodule

//--- booth_radix4_core.sv
module booth_radix4_core #(
	parameter int XLEN = mul_isa_pkg::xlen_default
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   opnd_valid,
	input  mul_dp_pkg::prep_opnd_t opnd,
	output logic                   busy,
	output logic                   prod_valid,
	output mul_dp_pkg::product_u   prod,
	output mul_isa_pkg::mul_op_e   prod_op,
	output logic                   prod_word
);
	import mul_isa_pkg::*;
	import mul_dp_pkg::*;

	localparam int OW    = XLEN + 2;     // extended operand width.
	localparam int AW    = 2 * OW;
	localparam int STEPS = XLEN / 2;
	localparam int CW    = $clog2(STEPS);

	booth_state_e  state;
	booth_state_e  state_nxt;
	logic [CW-1:0] step_cnt;
	logic          last_step;
	logic          load;
	logic          step;
	logic [AW-1:0] acc;
	logic [AW-1:0] mcand_sh;
	logic [OW:0]   mplier_sh;   // one extra bit below for the booth window.
	logic [AW-1:0] pp;
	mul_op_e       op_q;
	logic          word_q;

	assign last_step = (step_cnt == CW'(STEPS - 1));
	assign load      = (state == st_idle) && opnd_valid;
	assign step      = (state == st_run) || (state == st_done);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (opnd_valid)
					state_nxt = st_run;
			end
			st_run: begin
				if (last_step)
					state_nxt = st_done;
			end
			st_done: begin
				state_nxt = st_idle;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			step_cnt   <= '0;
			prod_valid <= 1'b0;
		end else begin
			state      <= state_nxt;
			prod_valid <= (state == st_done);
			if (state == st_run)
				step_cnt <= step_cnt + 1'b1;
			else
				step_cnt <= '0;
		end
	end

	// radix-4 recoding of the current window.
	always_comb begin
		case (mplier_sh[2:0])
			3'b001, 3'b010: pp = mcand_sh;
			3'b011:         pp = mcand_sh << 1;
			3'b100:         pp = -(mcand_sh << 1);
			3'b101, 3'b110: pp = -mcand_sh;
			default:        pp = '0;
		endcase
	end

	// the done cycle sees y[msb:msb-2], nonzero only for an unsigned multiplier.
	always_ff @(posedge clk) begin
		if (load) begin
			acc       <= '0;
			mcand_sh  <= {{OW{opnd.mcand[OW-1]}}, opnd.mcand};
			mplier_sh <= {opnd.mplier, 1'b0};
			op_q      <= opnd.op;
			word_q    <= opnd.word;
		end else if (step) begin
			acc       <= acc + pp;
			mcand_sh  <= mcand_sh << 2;
			mplier_sh <= {{2{mplier_sh[OW]}}, mplier_sh[OW:2]};
		end
	end

	assign busy      = (state != st_idle) || prod_valid;
	assign prod.full = acc[2*XLEN-1:0];
	assign prod_op   = op_q;
	assign prod_word = word_q;

endmodule

//--- mul_result_sel.sv
module mul_result_sel #(
	parameter int XLEN = mul_isa_pkg::xlen_default
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 prod_valid,
	input  mul_dp_pkg::product_u prod,
	input  mul_isa_pkg::mul_op_e prod_op,
	input  logic                 prod_word,
	output logic                 rsp_valid,
	output mul_isa_pkg::mul_rsp_t rsp
);
	import mul_isa_pkg::*;

	localparam int WW = 32;

	logic [XLEN-1:0] sel;

	always_comb begin
		if (prod_word)
			sel = {{(XLEN-WW){prod.half.lo[WW-1]}}, prod.half.lo[WW-1:0]};
		else if (prod_op == op_mul)
			sel = prod.half.lo;
		else
			sel = prod.half.hi;   // mulh, mulhsu, mulhu.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= prod_valid;
	end

	always_ff @(posedge clk) begin
		if (prod_valid)
			rsp.result <= sel;
	end

endmodule

//--- mul_unit.sv
module mul_unit #(
	parameter int XLEN = mul_isa_pkg::xlen_default
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  mul_isa_pkg::mul_req_t req,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output mul_isa_pkg::mul_rsp_t rsp
);
	import mul_isa_pkg::*;
	import mul_dp_pkg::*;

	logic       opnd_valid;
	prep_opnd_t opnd;
	logic       busy;
	logic       prod_valid;
	product_u   prod;
	mul_op_e    prod_op;
	logic       prod_word;

	mul_operand_prep #(.XLEN(XLEN)) i_prep (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.busy       (busy),
		.opnd_valid (opnd_valid),
		.opnd       (opnd)
	);

	booth_radix4_core #(.XLEN(XLEN)) i_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.opnd_valid (opnd_valid),
		.opnd       (opnd),
		.busy       (busy),
		.prod_valid (prod_valid),
		.prod       (prod),
		.prod_op    (prod_op),
		.prod_word  (prod_word)
	);

	mul_result_sel #(.XLEN(XLEN)) i_sel (
		.clk        (clk),
		.rst_n      (rst_n),
		.prod_valid (prod_valid),
		.prod       (prod),
		.prod_op    (prod_op),
		.prod_word  (prod_word),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp)
	);

endmodule

//--- tb_mul_ref.svh
`ifndef TB_MUL_REF_SVH
`define TB_MUL_REF_SVH

// 32-bit lcg with the usual multiplier and increment.
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected result, built from the operand extension rules of the m extension.
function automatic logic [63:0] ref_mul(
	input mul_op_e     op,
	input logic        word,
	input logic [63:0] src1,
	input logic [63:0] src2
);
	logic [63:0]  a;
	logic [63:0]  b;
	logic         a_signed;
	logic         b_signed;
	logic [127:0] a_ext;
	logic [127:0] b_ext;
	logic [127:0] full;

	a = word ? {{32{src1[31]}}, src1[31:0]} : src1;
	b = word ? {{32{src2[31]}}, src2[31:0]} : src2;

	a_signed = (op != op_mulhu);                     // only mulhu treats src1 as unsigned.
	b_signed = (op == op_mul) || (op == op_mulh);

	a_ext = a_signed ? {{64{a[63]}}, a} : {64'd0, a};
	b_ext = b_signed ? {{64{b[63]}}, b} : {64'd0, b};
	full  = a_ext * b_ext;                           // low 128 bits are exact for every mode.

	if (word)
		return {{32{full[31]}}, full[31:0]};
	else if (op == op_mul)
		return full[63:0];
	else
		return full[127:64];
endfunction

task automatic abort_run();
	$display("Errors found");
	$fatal(1, "simulation stopped after a failed check");
endtask

task automatic check_val(
	input string       name,
	input logic [63:0] got,
	input logic [63:0] exp
);
	if (got !== exp) begin
		$display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

`endif

//--- tb_mul_unit.sv
module tb_mul_unit;
	import mul_isa_pkg::*;

	localparam int XLEN        = 64;
	localparam int LATENCY     = XLEN / 2 + 3;   // accept edge to rsp_valid edge.
	localparam int N_DIRECTED  = 5 * 5 * 5;
	localparam int N_RANDOM    = 200;
	localparam int N_EXTRA     = 6;
	localparam int N_REQ       = N_DIRECTED + N_RANDOM + N_EXTRA;
	localparam int CYCLE_LIMIT = N_REQ * 40 + 200;

	typedef struct packed {
		logic [63:0] result;
		logic [31:0] cycle;    // rising edge count at acceptance.
	} expect_t;

	logic     clk;
	logic     rst_n;
	logic     req_valid;
	mul_req_t req;
	logic     req_ready;
	logic     rsp_valid;
	mul_rsp_t rsp;

	int          cycles = 0;
	int          last_accept = 0;
	int          last_rsp_cycle = 0;
	bit          have_prev = 1'b0;
	logic [31:0] lcg_state;
	logic [63:0] corner [5];
	expect_t     exp_q[$];

	`include "tb_mul_ref.svh"

	mul_unit #(.XLEN(XLEN)) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// counts rising edges and stops a run that hangs.
	initial begin
		forever begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > CYCLE_LIMIT) begin
				$display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
				abort_run();
			end
		end
	end

	task automatic rand_dword(output logic [63:0] v);
		lcg_state = lcg_next(lcg_state);
		v[63:32]  = lcg_state;
		lcg_state = lcg_next(lcg_state);
		v[31:0]   = lcg_state;
	endtask

	// presents one request and holds it until the unit takes it.
	task automatic send_req(
		input mul_op_e     op,
		input logic        word,
		input logic [63:0] a,
		input logic [63:0] b
	);
		expect_t e;
		bit      waited;

		@(negedge clk);
		req_valid = 1'b1;
		req.op    = op;
		req.word  = word;
		req.src1  = a;
		req.src2  = b;
		waited    = 1'b0;
		while (!req_ready) begin
			waited = 1'b1;
			@(negedge clk);
		end
		// ready must come back exactly one cycle after the previous response.
		if (have_prev && (waited || cycles < last_accept + LATENCY + 1)) begin
			check_val("req_ready rise cycle", cycles, last_accept + LATENCY + 1);
			check_val("req_ready after rsp_valid", cycles, last_rsp_cycle + 1);
		end
		e.result = ref_mul(op, word, a, b);
		e.cycle  = cycles + 1;    // taken at the coming rising edge.
		exp_q.push_back(e);
		last_accept = cycles + 1;
		have_prev   = 1'b1;
		@(posedge clk);
	endtask

	task automatic drop_req();
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	// compares every response with the oldest expected entry.
	initial begin
		expect_t e;

		forever begin
			@(negedge clk);
			if (rsp_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("response at time %0t with no request outstanding", $time);
					abort_run();
				end else begin
					e = exp_q.pop_front();
					check_val("rsp.result", rsp.result, e.result);
					check_val("rsp latency", cycles - e.cycle, LATENCY);
					last_rsp_cycle = cycles;
					@(negedge clk);
					check_val("rsp_valid second cycle", rsp_valid, 1'b0);
				end
			end
		end
	end

	initial begin
		int          i;
		int          j;
		int          k;
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] r;
		mul_op_e     op;

		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		lcg_state = 32'h7867;
		corner[0] = 64'd0;
		corner[1] = 64'd1;
		corner[2] = {64{1'b1}};
		corner[3] = 64'h8000_0000_0000_0000;
		corner[4] = 64'h7fff_ffff_ffff_ffff;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_val("req_ready after reset", req_ready, 1'b1);
		check_val("rsp_valid after reset", rsp_valid, 1'b0);

		// mul, mulh, mulhsu, mulhu, then mulw as k == 4.
		for (k = 0; k < 5; k++) begin
			op = (k == 4) ? op_mul : mul_op_e'(k[2:0]);
			for (i = 0; i < 5; i++) begin
				for (j = 0; j < 5; j++)
					send_req(op, k == 4, corner[i], corner[j]);
			end
		end

		for (i = 0; i < N_RANDOM; i++) begin
			rand_dword(a);
			rand_dword(b);
			lcg_state = lcg_next(lcg_state);
			r         = lcg_state;
			if (r[30:28] == 3'd0)
				a = corner[r[26:24] % 5];    // now and then a corner operand.
			if (r[22:20] == 3'd0)
				b = corner[r[18:16] % 5];
			send_req(mul_op_e'({1'b0, r[9:8]}), r[12], a, b);
		end

		// let the unit drain, then queue requests behind a busy multiply.
		drop_req();
		repeat (LATENCY + 15) @(negedge clk);
		send_req(op_mulhu, 1'b0, {64{1'b1}}, {64{1'b1}});
		send_req(op_mul, 1'b0, 64'd3, 64'd5);
		send_req(op_mulh, 1'b0, 64'h8000_0000_0000_0000, {64{1'b1}});
		send_req(op_mulhsu, 1'b0, {64{1'b1}}, {64{1'b1}});
		send_req(op_mul, 1'b1, 64'hffff_ffff_8000_0000, 64'h0000_0001_ffff_ffff);
		send_req(op_mulhu, 1'b0, 64'd0, {64{1'b1}});
		drop_req();

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2 * LATENCY) @(negedge clk);    // a second accept would answer here.

		$display("No errors");
		$finish;
	end

endmodule

//--- project.f
+incdir+.
mul_isa_pkg.sv
mul_dp_pkg.sv
mul_operand_prep.sv
booth_radix4_core.sv
mul_result_sel.sv
mul_unit.sv
tb_mul_unit.sv
